//--- build.f
+incdir+logic
logic/core_pkg.sv
logic/decode.sv
logic/execute.sv
logic/result.sv
logic/core_top.sv
verification/core_checker.sv
verification/core_tb.sv

//--- logic/core_cfg.svh
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

`define LEN_WORD        32
`define LEN_INST        32
`define NUM_REGS        32
`define LEN_VREG_ADDR   6

// base rv32 opcodes.
`define OP_ALU          7'b0110011
`define OP_ALUI         7'b0010011
`define OP_LUI          7'b0110111
`define OP_AUIPC        7'b0010111
`define OP_JAL          7'b1101111
`define OP_JALR         7'b1100111
`define OP_BRANCH       7'b1100011

// memory and float, decoded only.
`define OP_MEML         7'b0000011
`define OP_MEMS         7'b0100011
`define OP_FMEML        7'b0000111
`define OP_FMEMS        7'b0100111
`define OP_FPU          7'b1010011

// custom-0 / custom-1 slots for port i/o.
`define OP_INPUT        7'b0001011
`define OP_OUTPUT       7'b0101011

`endif

//--- logic/core_pkg.sv
`include "core_cfg.svh"

package core_pkg;

    typedef logic [`LEN_WORD-1:0]      word_t;
    typedef logic [`LEN_INST-1:0]      inst_t;
    typedef logic [`LEN_VREG_ADDR-1:0] vreg_addr_t; // msb is the float flag, 0 is unused.
    typedef logic [2:0]                func3_t;
    typedef logic [6:0]                func7_t;

    // exactly one flag per decoded instruction.
    typedef struct packed {
        logic alu;          // register form, func7 zero.
        logic alu_imm;
        logic alu_ext;      // register form, sub and sra.
        logic subst;        // lui, auipc.
        logic jump;         // jalr.
        logic jal;
        logic branch;
        logic unsupported;
    } exec_class_t;

    typedef struct packed {
        logic        valid;
        word_t       pc;
        exec_class_t cls;
        vreg_addr_t  rs1;
        vreg_addr_t  rs2;
        vreg_addr_t  rd;
        word_t       imm;       // alu operand or ready-made result.
        word_t       target;    // jal and branch target, jalr offset.
        func3_t      func3;
        func7_t      func7;
    } dec_exec_info_t;

    typedef struct packed {
        logic       valid;
        word_t      pc;
        vreg_addr_t rd;
        logic       we;
        word_t      value;
        word_t      next_pc;
        logic       trap;
    } exec_result_t;

endpackage

//--- logic/core_top.sv
module core_top import core_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       instr_valid,
    input  inst_t      instr,
    input  word_t      pc,
    output logic       retire_valid,
    output logic       retire_trap,
    output logic       retire_we,
    output word_t      retire_pc,
    output word_t      retire_value,
    output word_t      retire_next_pc,
    output logic [4:0] retire_rd
);

    dec_exec_info_t dec;
    exec_result_t   res;
    exec_result_t   bypass;
    logic [4:0]     rs1_idx;
    logic [4:0]     rs2_idx;
    word_t          rs1_data;
    word_t          rs2_data;

    decode i_decode (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .pc          (pc),
        .dec         (dec)
    );

    execute i_execute (
        .clk      (clk),
        .reset    (reset),
        .dec      (dec),
        .rs1_idx  (rs1_idx),
        .rs2_idx  (rs2_idx),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .bypass   (bypass),
        .res      (res)
    );

    result i_result (
        .clk            (clk),
        .reset          (reset),
        .res            (res),
        .rs1_idx        (rs1_idx),
        .rs2_idx        (rs2_idx),
        .rs1_data       (rs1_data),
        .rs2_data       (rs2_data),
        .bypass         (bypass),
        .retire_valid   (retire_valid),
        .retire_trap    (retire_trap),
        .retire_we      (retire_we),
        .retire_pc      (retire_pc),
        .retire_value   (retire_value),
        .retire_next_pc (retire_next_pc),
        .retire_rd      (retire_rd)
    );

endmodule

//--- logic/decode.sv
`include "core_cfg.svh"

module decode import core_pkg::*; (
    input  logic           clk,
    input  logic           reset,
    input  logic           instr_valid,
    input  inst_t          instr,
    input  word_t          pc,
    output dec_exec_info_t dec
);

    logic [6:0] opcode;
    logic       is_alu_r, alu_base, alu_ext, alu_imm;
    logic       subst, jal, jump, branch;
    logic       fpu, io, unsupported;

    assign opcode   = instr[6:0];
    assign is_alu_r = (opcode == `OP_ALU);
    assign alu_base = is_alu_r & (instr[31:25] == 7'b0000000);
    assign alu_ext  = is_alu_r & (instr[31:25] == 7'b0100000);
    assign alu_imm  = (opcode == `OP_ALUI);
    assign subst    = (opcode == `OP_LUI) | (opcode == `OP_AUIPC);
    assign jal      = (opcode == `OP_JAL);
    assign jump     = (opcode == `OP_JALR);
    assign branch   = (opcode == `OP_BRANCH);
    assign fpu      = (opcode == `OP_FPU);
    assign io       = (opcode == `OP_INPUT) | (opcode == `OP_OUTPUT);

    // m-extension and any unknown opcode land here too.
    assign unsupported = ~(alu_base | alu_imm | alu_ext | subst | jump | jal | branch);

    func3_t func3;
    func7_t func7;
    logic   no_use_func3, no_use_func7;

    assign no_use_func3 = subst | jal;
    assign no_use_func7 = ~(is_alu_r | fpu | io | (alu_imm & (instr[13:12] == 2'b01)));
    assign func3 = no_use_func3 ? 3'b000 : instr[14:12];
    assign func7 = no_use_func7 ? 7'b0000000 : instr[31:25];

    // float flags only mark the register address.
    logic io_float, fpu_cross, cross_dir;
    logic rs1_float, rs2_float, rd_float;

    assign io_float  = io & func7[5];
    assign fpu_cross = fpu & func7[6];     // moves and converts between banks.
    assign cross_dir = func7[3] ^ func7[4];
    assign rs1_float = (fpu & ~(fpu_cross & ~cross_dir)) | io_float;
    assign rs2_float = fpu | (opcode == `OP_FMEMS) | io_float;
    assign rd_float  = (fpu & ~(fpu_cross & cross_dir)) | (opcode == `OP_FMEML) | io_float;

    logic no_use_rd, no_use_rs1, no_use_rs2;

    assign no_use_rd  = (opcode == `OP_MEMS) | (opcode == `OP_FMEMS)
                      | (opcode == `OP_OUTPUT) | branch;
    assign no_use_rs1 = subst | jal | (opcode == `OP_INPUT);
    assign no_use_rs2 = ~(is_alu_r | branch | (opcode == `OP_MEMS)
                      | (opcode == `OP_FMEMS) | (fpu & ~func7[5]));

    vreg_addr_t va_rs1, va_rs2, va_rd;

    assign va_rs1 = no_use_rs1 ? '0 : {rs1_float, instr[19:15]};
    assign va_rs2 = no_use_rs2 ? '0 : {rs2_float, instr[24:20]};
    assign va_rd  = no_use_rd  ? '0 : {rd_float,  instr[11:7]};

    word_t imm_i, imm_s, imm_b, imm_j, imm_u;

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};

    word_t pc_plus4, sel_imm, sel_target;

    assign pc_plus4 = pc + 32'd4;

    always_comb begin
        if (alu_imm || (opcode == `OP_MEML) || (opcode == `OP_FMEML)) begin
            sel_imm = imm_i;
        end else if ((opcode == `OP_MEMS) || (opcode == `OP_FMEMS)) begin
            sel_imm = imm_s;
        end else if (jump || jal) begin
            sel_imm = pc_plus4;         // link value.
        end else if (opcode == `OP_LUI) begin
            sel_imm = imm_u;
        end else if (opcode == `OP_AUIPC) begin
            sel_imm = imm_u + pc;
        end else begin
            sel_imm = '0;
        end
    end

    always_comb begin
        if (jal) begin
            sel_target = pc + imm_j;
        end else if (jump) begin
            sel_target = imm_i;         // jalr offset to be added to rs1 in execute.
        end else if (branch) begin
            sel_target = pc + imm_b;
        end else begin
            sel_target = '0;
        end
    end

    dec_exec_info_t dec_next;

    always_comb begin
        dec_next                 = '0;
        dec_next.valid           = instr_valid;
        dec_next.pc              = pc;
        dec_next.cls.alu         = alu_base;
        dec_next.cls.alu_imm     = alu_imm;
        dec_next.cls.alu_ext     = alu_ext;
        dec_next.cls.subst       = subst;
        dec_next.cls.jump        = jump;
        dec_next.cls.jal         = jal;
        dec_next.cls.branch      = branch;
        dec_next.cls.unsupported = unsupported;
        dec_next.rs1             = va_rs1;
        dec_next.rs2             = va_rs2;
        dec_next.rd              = va_rd;
        dec_next.imm             = sel_imm;
        dec_next.target          = sel_target;
        dec_next.func3           = func3;
        dec_next.func7           = func7;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            dec.valid <= 1'b0;
        end else begin
            dec <= dec_next;
        end
    end

    a_class_onehot: assert property (@(posedge clk) disable iff (reset)
        dec.valid |-> $onehot0(dec.cls));

endmodule

//--- logic/execute.sv
module execute import core_pkg::*; (
    input  logic           clk,
    input  logic           reset,
    input  dec_exec_info_t dec,
    output logic [4:0]     rs1_idx,
    output logic [4:0]     rs2_idx,
    input  word_t          rs1_data,
    input  word_t          rs2_data,
    input  exec_result_t   bypass,
    output exec_result_t   res
);

    assign rs1_idx = dec.rs1[4:0];
    assign rs2_idx = dec.rs2[4:0];

    // the instruction ahead has not reached the file yet.
    logic  fwd1, fwd2;
    word_t op1, op2;

    assign fwd1 = bypass.valid & bypass.we & (dec.rs1 != '0) & (bypass.rd == dec.rs1);
    assign fwd2 = bypass.valid & bypass.we & (dec.rs2 != '0) & (bypass.rd == dec.rs2);
    assign op1  = fwd1 ? bypass.value : rs1_data;
    assign op2  = fwd2 ? bypass.value : rs2_data;

    word_t      alu_b, alu_out;
    logic [4:0] shamt;
    logic       alt;

    assign alu_b = dec.cls.alu_imm ? dec.imm : op2;
    assign shamt = alu_b[4:0];
    assign alt   = dec.cls.alu_ext | (dec.cls.alu_imm & dec.func7[5]); // sub or sra.

    always_comb begin
        case (dec.func3)
            3'b000:  alu_out = (alt && !dec.cls.alu_imm) ? op1 - alu_b : op1 + alu_b;
            3'b001:  alu_out = op1 << shamt;
            3'b010:  alu_out = {31'b0, $signed(op1) < $signed(alu_b)};
            3'b011:  alu_out = {31'b0, op1 < alu_b};
            3'b100:  alu_out = op1 ^ alu_b;
            3'b101:  alu_out = alt ? word_t'($signed(op1) >>> shamt) : op1 >> shamt;
            3'b110:  alu_out = op1 | alu_b;
            default: alu_out = op1 & alu_b;
        endcase
    end

    logic taken;

    always_comb begin
        case (dec.func3)
            3'b000:  taken = (op1 == op2);
            3'b001:  taken = (op1 != op2);
            3'b100:  taken = ($signed(op1) < $signed(op2));
            3'b101:  taken = ($signed(op1) >= $signed(op2));
            3'b110:  taken = (op1 < op2);
            3'b111:  taken = (op1 >= op2);
            default: taken = 1'b0;  // reserved encodings fall through.
        endcase
    end

    word_t next_pc, jalr_sum, value;
    logic  is_alu, we;

    assign jalr_sum = op1 + dec.target;
    assign is_alu   = dec.cls.alu | dec.cls.alu_imm | dec.cls.alu_ext;

    always_comb begin
        if (dec.cls.branch && taken) begin
            next_pc = dec.target;
        end else if (dec.cls.jump) begin
            next_pc = {jalr_sum[31:1], 1'b0};
        end else if (dec.cls.jal) begin
            next_pc = dec.target;
        end else begin
            next_pc = dec.pc + 32'd4;
        end
    end

    always_comb begin
        if (is_alu) begin
            value = alu_out;
        end else if (dec.cls.subst || dec.cls.jal || dec.cls.jump) begin
            value = dec.imm;        // precomputed in decode.
        end else begin
            value = '0;
        end
    end

    assign we = (dec.rd != '0) & ~dec.cls.unsupported & ~dec.cls.branch;

    exec_result_t res_next;

    always_comb begin
        res_next.valid   = dec.valid;
        res_next.pc      = dec.pc;
        res_next.rd      = dec.rd;
        res_next.we      = we;
        res_next.value   = value;
        res_next.next_pc = next_pc;
        res_next.trap    = dec.cls.unsupported;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            res.valid <= 1'b0;
        end else begin
            res <= res_next;
        end
    end

    // an unsupported op must retire as a trap without touching the file.
    a_trap_no_write: assert property (@(posedge clk) disable iff (reset)
        dec.valid && dec.cls.unsupported |=> res.valid && res.trap && !res.we);

endmodule

//--- logic/result.sv
`include "core_cfg.svh"

module result import core_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  exec_result_t res,
    input  logic [4:0]   rs1_idx,
    input  logic [4:0]   rs2_idx,
    output word_t        rs1_data,
    output word_t        rs2_data,
    output exec_result_t bypass,
    output logic         retire_valid,
    output logic         retire_trap,
    output logic         retire_we,
    output word_t        retire_pc,
    output word_t        retire_value,
    output word_t        retire_next_pc,
    output logic [4:0]   retire_rd
);

    word_t regs [`NUM_REGS];
    logic  wr_en;

    assign wr_en = res.valid & res.we;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            regs[res.rd[4:0]] <= res.value;
        end
    end

    // x0 is hardwired.
    assign rs1_data = (rs1_idx == 5'd0) ? '0 : regs[rs1_idx];
    assign rs2_data = (rs2_idx == 5'd0) ? '0 : regs[rs2_idx];

    // write still in flight this cycle.
    assign bypass = res;

    assign retire_valid   = res.valid;
    assign retire_trap    = res.valid & res.trap;
    assign retire_we      = wr_en;
    assign retire_pc      = res.pc;
    assign retire_value   = res.value;
    assign retire_next_pc = res.next_pc;
    assign retire_rd      = res.rd[4:0];

    a_no_x0_write: assert property (@(posedge clk) disable iff (reset)
        wr_en |-> (res.rd[4:0] != 5'd0));

    // float flag never reaches the integer file.
    a_int_dest: assert property (@(posedge clk) disable iff (reset)
        wr_en |-> !res.rd[5]);

endmodule

//--- verification/core_checker.sv
`include "core_cfg.svh"

module core_checker import core_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       instr_valid,
    input  inst_t      instr,
    input  word_t      pc,
    input  logic       retire_valid,
    input  logic       retire_trap,
    input  logic       retire_we,
    input  word_t      retire_pc,
    input  word_t      retire_value,
    input  word_t      retire_next_pc,
    input  logic [4:0] retire_rd,
    output int         errors,
    output int         retired,
    output int         pending
);

    localparam int RETIRE_LATENCY = 2;     // sampling edge to the edge that sees retire.

    typedef logic [`NUM_REGS-1:0][`LEN_WORD-1:0] model_regs_t;

    typedef struct packed {
        word_t       pc;
        word_t       next_pc;
        word_t       value;
        logic        check_value;    // branches and traps carry no result.
        logic [4:0]  rd;
        logic        we;
        logic        trap;
        logic [31:0] accepted;       // cycle the instruction was sampled.
    } expect_t;

    model_regs_t model_regs;
    expect_t     exp_q[$];
    int          reset_edges;
    int          cycle;

    initial begin
        errors      = 0;
        retired     = 0;
        pending     = 0;
        reset_edges = 0;
        cycle       = 0;
        model_regs  = '0;
    end

    function automatic word_t alu_calc(input logic [2:0] f3, input logic alt,
                                       input word_t x, input word_t y);
        logic signed [31:0] sx, sy;
        word_t              v;
        sx = x;
        sy = y;
        case (f3)
            3'b000:  v = alt ? x - y : x + y;
            3'b001:  v = x << y[4:0];
            3'b010:  v = {31'b0, sx < sy};
            3'b011:  v = {31'b0, x < y};
            3'b100:  v = x ^ y;
            3'b101: begin
                if (alt) v = sx >>> y[4:0];
                else v = x >> y[4:0];
            end
            3'b110:  v = x | y;
            default: v = x & y;
        endcase
        return v;
    endfunction

    function automatic expect_t reference_model(input inst_t ins, input word_t ipc,
                                                input model_regs_t r);
        expect_t            e;
        logic [2:0]         f3;
        logic [6:0]         f7;
        word_t              a, b, imm_i, imm_b, imm_j, imm_u;
        logic               writes, taken;
        logic signed [31:0] sa, sb;
        f3    = ins[14:12];
        f7    = ins[31:25];
        a     = r[ins[19:15]];
        b     = r[ins[24:20]];
        sa    = a;
        sb    = b;
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        imm_u = {ins[31:12], 12'b0};
        e             = '0;
        e.pc          = ipc;
        e.next_pc     = ipc + 32'd4;
        e.rd          = ins[11:7];
        e.check_value = 1'b1;
        writes        = 1'b1;
        taken         = 1'b0;
        case (ins[6:0])
            `OP_ALU: begin
                if (f7 == 7'b0000000 || f7 == 7'b0100000) e.value = alu_calc(f3, f7[5], a, b);
                else e.trap = 1'b1;     // m-extension.
            end
            `OP_ALUI:  e.value = alu_calc(f3, (f3 == 3'b101) && ins[30], a, imm_i);
            `OP_LUI:   e.value = imm_u;
            `OP_AUIPC: e.value = imm_u + ipc;
            `OP_JAL: begin
                e.value   = ipc + 32'd4;
                e.next_pc = ipc + imm_j;
            end
            `OP_JALR: begin
                e.value   = ipc + 32'd4;
                e.next_pc = (a + imm_i) & ~32'd1;
            end
            `OP_BRANCH: begin
                case (f3)
                    3'b000:  taken = (a == b);
                    3'b001:  taken = (a != b);
                    3'b100:  taken = (sa < sb);
                    3'b101:  taken = (sa >= sb);
                    3'b110:  taken = (a < b);
                    3'b111:  taken = (a >= b);
                    default: taken = 1'b0;
                endcase
                if (taken) e.next_pc = ipc + imm_b;
                e.rd          = 5'd0;
                writes        = 1'b0;
                e.check_value = 1'b0;
            end
            default: e.trap = 1'b1;
        endcase
        if (e.trap) begin
            writes        = 1'b0;
            e.check_value = 1'b0;
            if (ins[6:0] == `OP_MEMS || ins[6:0] == `OP_FMEMS || ins[6:0] == `OP_OUTPUT) begin
                e.rd = 5'd0;    // store formats have no destination.
            end
        end
        e.we = writes && (e.rd != 5'd0);
        return e;
    endfunction

    task automatic check_field(input string name, input word_t expv, input word_t actv);
        if (actv !== expv) begin
            errors++;
            $display("mismatch at %0t: %s expected %h actual %h", $time, name, expv, actv);
        end
    endtask

    always @(posedge clk) begin
        expect_t e;
        if (reset) begin
            if (reset_edges > 0 && retire_valid !== 1'b0) begin
                errors++;
                $display("retire_valid is not low during reset at %0t", $time);
            end
            reset_edges++;
        end else begin
            if (retire_valid === 1'b1) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("retire at %0t without an accepted instruction", $time);
                end else begin
                    e = exp_q.pop_front();
                    retired++;
                    if (cycle - e.accepted != RETIRE_LATENCY) begin
                        errors++;
                        $display("instruction at pc %h retired %0d cycles after it was taken at %0t",
                                 e.pc, cycle - e.accepted, $time);
                    end
                    check_field("retire_pc", e.pc, retire_pc);
                    check_field("retire_next_pc", e.next_pc, retire_next_pc);
                    if (e.check_value) check_field("retire_value", e.value, retire_value);
                    check_field("retire_rd", {27'b0, e.rd}, {27'b0, retire_rd});
                    check_field("retire_we", {31'b0, e.we}, {31'b0, retire_we});
                    check_field("retire_trap", {31'b0, e.trap}, {31'b0, retire_trap});
                end
            end else if (retire_valid !== 1'b0) begin
                errors++;
                $display("retire_valid is unknown at %0t", $time);
            end
            if (instr_valid === 1'b1) begin
                e = reference_model(instr, pc, model_regs);
                e.accepted = cycle;
                if (e.we) model_regs[e.rd] = e.value;   // in order like the core.
                exp_q.push_back(e);
            end
            pending = exp_q.size();
            cycle++;
        end
    end

endmodule

//--- verification/core_tb.sv
`include "core_cfg.svh"

module core_tb import core_pkg::*; ();

    localparam int N_INIT    = 62;
    localparam int N_ALU     = 200;
    localparam int N_CHAIN   = 60;
    localparam int N_BRANCH  = 60;
    localparam int N_JUMP    = 40;
    localparam int N_UPPER   = 30;
    localparam int N_TRAP    = 32;   // each one followed by a read-back.
    localparam int NUM_INSTR = N_INIT + N_ALU + N_CHAIN + N_BRANCH + N_JUMP + N_UPPER + 2 * N_TRAP;
    localparam int TIMEOUT   = (NUM_INSTR + 20) * 10;

    logic       clk;
    logic       reset;
    logic       instr_valid;
    inst_t      instr;
    word_t      pc;
    logic       retire_valid;
    logic       retire_trap;
    logic       retire_we;
    word_t      retire_pc;
    word_t      retire_value;
    word_t      retire_next_pc;
    logic [4:0] retire_rd;
    int         errors;
    int         retired;
    int         pending;
    integer     seed;
    word_t      cur_pc;

    core_top i_dut (
        .clk            (clk),
        .reset          (reset),
        .instr_valid    (instr_valid),
        .instr          (instr),
        .pc             (pc),
        .retire_valid   (retire_valid),
        .retire_trap    (retire_trap),
        .retire_we      (retire_we),
        .retire_pc      (retire_pc),
        .retire_value   (retire_value),
        .retire_next_pc (retire_next_pc),
        .retire_rd      (retire_rd)
    );

    core_checker i_checker (
        .clk            (clk),
        .reset          (reset),
        .instr_valid    (instr_valid),
        .instr          (instr),
        .pc             (pc),
        .retire_valid   (retire_valid),
        .retire_trap    (retire_trap),
        .retire_we      (retire_we),
        .retire_pc      (retire_pc),
        .retire_value   (retire_value),
        .retire_next_pc (retire_next_pc),
        .retire_rd      (retire_rd),
        .errors         (errors),
        .retired        (retired),
        .pending        (pending)
    );

    always #5 clk = ~clk;

    task automatic issue(input inst_t ins);
        @(posedge clk);
        instr_valid <= 1'b1;
        instr       <= ins;
        pc          <= cur_pc;
        cur_pc = cur_pc + 32'd4;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            instr_valid <= 1'b0;
        end
    endtask

    // random register or immediate op with x0 as destination one time in eight.
    function automatic inst_t alu_instr(input word_t rb, input logic [4:0] rs1);
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [11:0] imm;
        f3  = rb[2:0];
        rd  = (rb[5:3] == 3'b000) ? 5'd0 : rb[10:6];
        imm = rb[31:20];
        if (rb[11]) begin
            return {(rb[12] && (f3 == 3'b000 || f3 == 3'b101)) ? 7'b0100000 : 7'b0000000,
                    rb[17:13], rs1, f3, rd, `OP_ALU};
        end
        if (f3 == 3'b001) imm[11:5] = 7'b0;
        else if (f3 == 3'b101) imm[11:5] = {1'b0, rb[12], 5'b0};    // srli or srai.
        return {imm, rs1, f3, rd, `OP_ALUI};
    endfunction

    function automatic inst_t branch_instr(input logic [12:0] off, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `OP_BRANCH};
    endfunction

    function automatic inst_t jal_instr(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, `OP_JAL};
    endfunction

    function automatic inst_t trap_instr(input int k, input word_t bits);
        inst_t ins;
        ins = bits;
        case (k % 8)
            0: ins[6:0] = `OP_MEML;
            1: ins[6:0] = `OP_MEMS;
            2: ins[6:0] = `OP_FMEML;
            3: ins[6:0] = `OP_FMEMS;
            4: ins[6:0] = `OP_FPU;
            5: ins[6:0] = `OP_INPUT;
            6: ins[6:0] = `OP_OUTPUT;
            default: begin
                ins[6:0]   = `OP_ALU;
                ins[31:25] = 7'b0000001;    // mul and div group.
            end
        endcase
        return ins;
    endfunction

    initial begin
        word_t      r;
        inst_t      ins;
        logic [2:0] f3;
        logic [4:0] rs1, last_rd;
        clk         = 1'b0;
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        pc          = '0;
        seed        = 68625;
        cur_pc      = 32'h0000_1000;
        last_rd     = 5'd1;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        idle_cycles(3);
        for (int i = 1; i < 32; i++) begin     // the file has no reset so fill it first.
            r = $random(seed);
            issue({r[31:12], 5'(i), `OP_LUI});
            issue({r[11:0], 5'(i), 3'b000, 5'(i), `OP_ALUI});
        end
        repeat (N_ALU) begin
            r = $random(seed);
            issue(alu_instr(r, r[30:26]));
        end
        repeat (N_CHAIN) begin
            r   = $random(seed);
            ins = alu_instr(r, last_rd);
            issue(ins);
            if (ins[11:7] != 5'd0) last_rd = ins[11:7];
        end
        repeat (N_BRANCH) begin
            r  = $random(seed);
            f3 = r[2:0];
            if (f3[2:1] == 2'b01) f3[2] = 1'b1;
            rs1 = r[7:3];
            issue(branch_instr({r[31:20], 1'b0}, r[8] ? rs1 : r[13:9], rs1, f3));
        end
        for (int i = 0; i < N_JUMP; i++) begin
            r = $random(seed);
            if (i % 2 == 0) issue(jal_instr({r[31:12], 1'b0}, r[4:0]));
            else issue({r[31:20], r[9:5], 3'b000, r[4:0], `OP_JALR});
        end
        repeat (N_UPPER) begin
            r = $random(seed);
            issue({r[31:12], r[4:0], r[5] ? `OP_LUI : `OP_AUIPC});
        end
        for (int i = 0; i < N_TRAP; i++) begin
            r   = $random(seed);
            ins = trap_instr(i, r);
            issue(ins);
            issue({7'b0, 5'd0, ins[11:7], 3'b000, 5'd0, `OP_ALU});  // add x0 reads it back.
        end
        idle_cycles(5);
        @(negedge clk);
        if (pending != 0) $display("%0d expected retirements never showed up", pending);
        $display("summary: %0d retired, %0d errors, %0d left in queue", retired, errors, pending);
        if (errors == 0 && pending == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT);
        $display("timeout: run did not end within %0d time units", TIMEOUT);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule
